//--- src/bsc_pkg.sv
package bsc_pkg;

   // Data path and bit counter widths
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // Decoded instruction class
   typedef enum logic [2:0] {
      op_alu_reg,
      op_alu_imm,
      op_lui,
      op_load,
      op_store,
      op_branch,
      op_jal,
      op_illegal
   } op_class_e;

   // ALU function
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor
   } alu_op_e;

   // Sequencer phase
   typedef enum logic [2:0] {
      st_fetch,
      st_decode,
      st_exec,
      st_mem,
      st_load_wb
   } seq_state_e;

endpackage

//--- src/bsc_decode.sv
`timescale 1ns/1ps

module bsc_decode import bsc_pkg::*; (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [XLEN-1:0]  i_ibus_rdt,
   input  logic             i_ibus_ack,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_cnt_en,
   output op_class_e        o_class,
   output alu_op_e          o_alu_op,
   output logic             o_branch_ne,
   output logic [4:0]       o_rs1_addr,
   output logic [4:0]       o_rs2_addr,
   output logic [4:0]       o_rd_addr,
   output logic             o_imm
);

   logic [XLEN-1:0] ir;
   logic [XLEN-1:0] imm_word;
   logic [6:0]      opcode;
   logic [2:0]      funct3;

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ir <= '0;
      end else if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   always_comb begin
      o_class  = op_illegal;
      o_alu_op = alu_add;
      imm_word = {{20{ir[31]}}, ir[31:20]};
      case (opcode)
         7'b0110011, 7'b0010011: begin
            o_class = opcode[5] ? op_alu_reg : op_alu_imm;
            case (funct3)
               3'b000:  o_alu_op = (opcode[5] && ir[30]) ? alu_sub : alu_add;
               3'b100:  o_alu_op = alu_xor;
               3'b110:  o_alu_op = alu_or;
               3'b111:  o_alu_op = alu_and;
               default: o_class = op_illegal;
            endcase
         end
         7'b0110111: begin
            o_class  = op_lui;
            imm_word = {ir[31:12], 12'b0};
         end
         7'b0000011: begin
            // Word loads only
            if (funct3 == 3'b010) o_class = op_load;
         end
         7'b0100011: begin
            if (funct3 == 3'b010) o_class = op_store;
            imm_word = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         end
         7'b1100011: begin
            if (funct3[2:1] == 2'b00) o_class = op_branch;
            imm_word = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         end
         7'b1101111: begin
            o_class  = op_jal;
            imm_word = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         end
         default: o_class = op_illegal;
      endcase
   end

   // LUI adds its immediate to x0
   assign o_rs1_addr  = (o_class == op_lui) ? 5'd0 : ir[19:15];
   assign o_rs2_addr  = ir[24:20];
   assign o_rd_addr   = ir[11:7];
   assign o_branch_ne = funct3[0];
   assign o_imm       = i_cnt_en & imm_word[i_cnt];

   assert property (@(posedge clk) disable iff (!i_rst_n)
      i_cnt_en |-> !$isunknown(o_class));

endmodule

//--- src/bsc_state.sv
`timescale 1ns/1ps

module bsc_state import bsc_pkg::*; (
   input  logic             clk,
   input  logic             i_rst_n,
   input  op_class_e        i_class,
   input  logic             i_ibus_ack,
   input  logic             i_dbus_ack,
   output seq_state_e       o_state,
   output logic [CNT_W-1:0] o_cnt,
   output logic             o_cnt_en,
   output logic             o_cnt_done,
   output logic             o_init,
   output logic             o_rd_wen,
   output logic             o_ibus_cyc,
   output logic             o_dbus_cyc
);

   seq_state_e state_next;

   assign o_cnt_en   = (o_state == st_exec) || (o_state == st_load_wb);
   assign o_cnt_done = o_cnt_en && (&o_cnt);
   assign o_init     = (o_state == st_exec) && (o_cnt == '0);

   // x0 filtering happens in the register file
   assign o_rd_wen = (o_state == st_load_wb) ||
                     ((o_state == st_exec) &&
                      (i_class inside {op_alu_reg, op_alu_imm, op_lui, op_jal}));

   always_comb begin
      state_next = o_state;
      case (o_state)
         st_fetch:   if (o_ibus_cyc && i_ibus_ack) state_next = st_decode;
         st_decode:  state_next = st_exec;
         st_exec: begin
            if (o_cnt_done) begin
               state_next = (i_class inside {op_load, op_store}) ? st_mem : st_fetch;
            end
         end
         st_mem: begin
            if (o_dbus_cyc && i_dbus_ack) begin
               state_next = (i_class == op_load) ? st_load_wb : st_fetch;
            end
         end
         st_load_wb: if (o_cnt_done) state_next = st_fetch;
         default:    state_next = st_fetch;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_state    <= st_fetch;
         o_cnt      <= '0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         o_state    <= state_next;
         // Bus requests follow the phase one cycle ahead
         o_ibus_cyc <= (state_next == st_fetch);
         o_dbus_cyc <= (state_next == st_mem);
         if (o_cnt_en) o_cnt <= o_cnt + 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (!i_rst_n) !(o_ibus_cyc && o_dbus_cyc));
   assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc);
   assert property (@(posedge clk) disable iff (!i_rst_n)
      o_dbus_cyc && !i_dbus_ack |=> o_dbus_cyc);

endmodule

//--- src/bsc_alu.sv
`timescale 1ns/1ps

module bsc_alu import bsc_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  alu_op_e i_alu_op,
   input  logic    i_init,
   input  logic    i_cnt_en,
   input  logic    i_cnt_done,
   input  logic    i_rs1,
   input  logic    i_op_b,
   output logic    o_rd,
   output logic    o_eq
);

   logic carry_q;
   logic eq_q;
   logic sub;
   logic b_eff;
   logic cin;
   logic sum;
   logic eq_run;

   // Subtract as rs1 + ~b + 1
   assign sub    = (i_alu_op == alu_sub);
   assign b_eff  = sub ? ~i_op_b : i_op_b;
   assign cin    = i_init ? sub : carry_q;
   assign sum    = i_rs1 ^ b_eff ^ cin;
   assign eq_run = (i_init ? 1'b1 : eq_q) & (i_rs1 ~^ i_op_b);
   assign o_eq   = i_cnt_done & eq_run;

   always_comb begin
      case (i_alu_op)
         alu_and: o_rd = i_rs1 & i_op_b;
         alu_or:  o_rd = i_rs1 | i_op_b;
         alu_xor: o_rd = i_rs1 ^ i_op_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_eff) | (i_rs1 & cin) | (b_eff & cin);
         eq_q    <= eq_run;
      end
   end

endmodule

//--- src/bsc_regfile.sv
`timescale 1ns/1ps

module bsc_regfile import bsc_pkg::*; (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_cnt_en,
   input  logic [4:0]       i_rs1_addr,
   input  logic [4:0]       i_rs2_addr,
   input  logic [4:0]       i_rd_addr,
   input  logic             i_rd_wen,
   input  logic             i_rd,
   output logic             o_rs1,
   output logic             o_rs2
);

   logic [XLEN-1:0] regs [32];

   // Reads see the old bit when rd equals a source
   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_rd_wen && (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // Write enable only ever arrives inside a counted pass
   assert property (@(posedge clk) disable iff (!i_rst_n) i_rd_wen |-> i_cnt_en);

endmodule

//--- src/bsc_ctrl.sv
`timescale 1ns/1ps

module bsc_ctrl import bsc_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  op_class_e       i_class,
   input  logic            i_eq,
   input  logic            i_branch_ne,
   input  logic            i_imm,
   input  logic            i_cnt_en,
   input  logic            i_cnt_done,
   input  logic            i_init,
   output logic            o_pc_bit,
   output logic [XLEN-1:0] o_ibus_adr
);

   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] pc_sh;
   logic [XLEN-1:0] pc4_sh;
   logic [XLEN-1:0] tgt_sh;
   logic [1:0]      four_sh;
   logic            exec_q;
   logic            c4_q;
   logic            ct_q;
   logic            run;
   logic            pc_b;
   logic            four_b;
   logic            c4_in;
   logic            ct_in;
   logic            pc4_b;
   logic            tgt_b;
   logic            take;

   // Only the execute pass counts, not load write-back
   assign run    = i_init | exec_q;
   assign pc_b   = i_init ? pc[0] : pc_sh[0];
   assign four_b = i_init ? 1'b0 : four_sh[0];
   assign c4_in  = ~i_init & c4_q;
   assign ct_in  = ~i_init & ct_q;
   assign pc4_b  = pc_b ^ four_b ^ c4_in;
   assign tgt_b  = pc_b ^ i_imm ^ ct_in;
   assign take   = (i_class == op_jal) ||
                   ((i_class == op_branch) && (i_eq ^ i_branch_ne));

   assign o_pc_bit   = pc4_b;
   assign o_ibus_adr = pc;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc      <= RESET_PC;
         exec_q  <= 1'b0;
         c4_q    <= 1'b0;
         ct_q    <= 1'b0;
         four_sh <= '0;
      end else begin
         if (i_init) exec_q <= 1'b1;
         else if (i_cnt_done) exec_q <= 1'b0;
         if (i_cnt_en && run) begin
            c4_q    <= (pc_b & four_b) | (pc_b & c4_in) | (four_b & c4_in);
            ct_q    <= (pc_b & i_imm) | (pc_b & ct_in) | (i_imm & ct_in);
            // Bit 2 of the constant four
            four_sh <= i_init ? 2'b10 : {1'b0, four_sh[1]};
         end
         if (i_cnt_done && run) begin
            pc <= take ? {tgt_b, tgt_sh[XLEN-1:1]} : {pc4_b, pc4_sh[XLEN-1:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en && run) begin
         pc_sh  <= {1'b0, (i_init ? pc[XLEN-1:1] : pc_sh[XLEN-1:1])};
         pc4_sh <= {pc4_b, pc4_sh[XLEN-1:1]};
         tgt_sh <= {tgt_b, tgt_sh[XLEN-1:1]};
      end
   end

endmodule

//--- src/bsc_mem_if.sv
`timescale 1ns/1ps

module bsc_mem_if import bsc_pkg::*; (
   input  logic            clk,
   input  logic            i_rst_n,
   input  seq_state_e      i_state,
   input  op_class_e       i_class,
   input  logic            i_cnt_en,
   input  logic            i_adr_bit,
   input  logic            i_rs2,
   input  logic            i_dbus_ack,
   input  logic [XLEN-1:0] i_dbus_rdt,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_dbus_we,
   output logic            o_rd
);

   logic [XLEN-1:0] rdat;

   assign o_dbus_we = (i_state == st_mem) && (i_class == op_store);
   assign o_rd      = rdat[0];

   always_ff @(posedge clk) begin
      // Address is rs1 + imm from the ALU sum
      if ((i_state == st_exec) && i_cnt_en) begin
         o_dbus_adr <= {i_adr_bit, o_dbus_adr[XLEN-1:1]};
         o_dbus_dat <= {i_rs2, o_dbus_dat[XLEN-1:1]};
      end
      if ((i_state == st_mem) && i_dbus_ack) begin
         rdat <= i_dbus_rdt;
      end else if ((i_state == st_load_wb) && i_cnt_en) begin
         rdat <= {1'b0, rdat[XLEN-1:1]};
      end
   end

   // Write strobe holds while the data bus waits
   assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_state == st_mem) && !i_dbus_ack |=> $stable(o_dbus_we));

endmodule

//--- src/bsc_top.sv
`timescale 1ns/1ps

module bsc_top import bsc_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc,
   input  logic [XLEN-1:0] i_dbus_rdt,
   input  logic            i_dbus_ack
);

   op_class_e        op_class;
   alu_op_e          alu_op;
   seq_state_e       state;
   logic [4:0]       rs1_addr;
   logic [4:0]       rs2_addr;
   logic [4:0]       rd_addr;
   logic [CNT_W-1:0] cnt;
   logic             cnt_en;
   logic             cnt_done;
   logic             init;
   logic             rd_wen;
   logic             branch_ne;
   logic             imm;
   logic             rs1;
   logic             rs2;
   logic             op_b;
   logic             alu_rd;
   logic             eq;
   logic             pc_bit;
   logic             mem_rd;
   logic             rd_bit;

   assign op_b   = (op_class inside {op_alu_reg, op_branch}) ? rs2 : imm;
   // Write-back source for rd
   assign rd_bit = (op_class == op_jal) ? pc_bit :
                   (state == st_load_wb) ? mem_rd : alu_rd;

   bsc_state u_state (
      .clk(clk), .i_rst_n(i_rst_n), .i_class(op_class),
      .i_ibus_ack(i_ibus_ack), .i_dbus_ack(i_dbus_ack),
      .o_state(state), .o_cnt(cnt), .o_cnt_en(cnt_en), .o_cnt_done(cnt_done),
      .o_init(init), .o_rd_wen(rd_wen), .o_ibus_cyc(o_ibus_cyc), .o_dbus_cyc(o_dbus_cyc));

   bsc_decode u_decode (
      .clk(clk), .i_rst_n(i_rst_n), .i_ibus_rdt(i_ibus_rdt),
      .i_ibus_ack(o_ibus_cyc & i_ibus_ack), .i_cnt(cnt), .i_cnt_en(cnt_en),
      .o_class(op_class), .o_alu_op(alu_op), .o_branch_ne(branch_ne),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr), .o_imm(imm));

   bsc_regfile u_regfile (
      .clk(clk), .i_rst_n(i_rst_n), .i_cnt(cnt), .i_cnt_en(cnt_en),
      .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
      .i_rd_wen(rd_wen), .i_rd(rd_bit), .o_rs1(rs1), .o_rs2(rs2));

   bsc_alu u_alu (
      .clk(clk), .i_rst_n(i_rst_n), .i_alu_op(alu_op), .i_init(init),
      .i_cnt_en(cnt_en), .i_cnt_done(cnt_done), .i_rs1(rs1), .i_op_b(op_b),
      .o_rd(alu_rd), .o_eq(eq));

   bsc_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
      .clk(clk), .i_rst_n(i_rst_n), .i_class(op_class), .i_eq(eq),
      .i_branch_ne(branch_ne), .i_imm(imm), .i_cnt_en(cnt_en), .i_cnt_done(cnt_done),
      .i_init(init), .o_pc_bit(pc_bit), .o_ibus_adr(o_ibus_adr));

   bsc_mem_if u_mem_if (
      .clk(clk), .i_rst_n(i_rst_n), .i_state(state), .i_class(op_class),
      .i_cnt_en(cnt_en), .i_adr_bit(alu_rd), .i_rs2(rs2), .i_dbus_ack(i_dbus_ack),
      .i_dbus_rdt(i_dbus_rdt), .o_dbus_adr(o_dbus_adr), .o_dbus_dat(o_dbus_dat),
      .o_dbus_we(o_dbus_we), .o_rd(mem_rd));

endmodule

//--- verif/bsc_checker.sv
`timescale 1ns/1ps

module bsc_checker #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_ibus_adr,
   input  logic        i_ibus_cyc,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_dbus_adr,
   input  logic [31:0] i_dbus_dat,
   input  logic        i_dbus_we,
   input  logic        i_dbus_cyc,
   input  logic        i_dbus_ack,
   output logic        o_done,
   output int          o_pass_cnt,
   output int          o_fail_cnt
);

   logic [31:0] pat [0:255];
   int          n_exp;
   int          idx;
   int          bp_errs;
   int          waits;
   logic        reset_bad;
   logic        first_seen;
   logic        ib_wait_q;
   logic        db_wait_q;
   logic [31:0] ib_adr_q;
   logic [31:0] db_adr_q;
   logic [31:0] db_dat_q;
   logic        db_we_q;

   initial begin
      for (int i = 0; i < 256; i++) pat[i] = 32'hbad00000 | i;
      $readmemh("verif/bsc_patterns.hex", pat);
      n_exp = 0;
      while (n_exp < 16 && pat[96 + 2 * n_exp] !== 32'hffffffff) n_exp++;
      idx        = 0;
      bp_errs    = 0;
      waits      = 0;
      o_done     = 1'b0;
      o_pass_cnt = 0;
      o_fail_cnt = 0;
      reset_bad  = 1'b0;
      first_seen = 1'b0;
      ib_wait_q  = 1'b0;
      db_wait_q  = 1'b0;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Fail t=%0t %s expected %08h got %08h", $time, name, exp, got);
      o_fail_cnt++;
   endtask

   task automatic compare_store();
      logic ok;
      ok = 1'b1;
      if (idx >= n_exp) begin
         $display("Fail t=%0t unexpected store to %08h after the last expected one",
                  $time, i_dbus_adr);
         o_fail_cnt++;
      end else begin
         if (i_dbus_adr !== pat[96 + 2 * idx]) begin
            report_mismatch("o_dbus_adr", pat[96 + 2 * idx], i_dbus_adr);
            ok = 1'b0;
         end
         if (i_dbus_dat !== pat[97 + 2 * idx]) begin
            report_mismatch("o_dbus_dat", pat[97 + 2 * idx], i_dbus_dat);
            ok = 1'b0;
         end
         if (ok) begin
            $display("store %0d: [%08h] <= %08h ok", idx, i_dbus_adr, i_dbus_dat);
            o_pass_cnt++;
         end
         idx++;
         if (idx == n_exp) begin
            if (bp_errs == 0) begin
               $display("back-pressure: outputs held over %0d waiting cycles ok", waits);
               o_pass_cnt++;
            end
            o_done <= 1'b1;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!i_rst_n) begin
         if (i_ibus_cyc !== 1'b0 || i_dbus_cyc !== 1'b0 || i_dbus_we !== 1'b0) begin
            if (!reset_bad) $display("Fail t=%0t bus request active during reset", $time);
            reset_bad = 1'b1;
         end
      end else begin
         if (!first_seen && i_ibus_cyc === 1'b1) begin
            first_seen = 1'b1;
            if (i_ibus_adr !== RESET_PC) begin
               report_mismatch("o_ibus_adr", RESET_PC, i_ibus_adr);
            end else if (reset_bad) begin
               o_fail_cnt++;
            end else begin
               $display("reset: buses idle, first fetch at %08h ok", i_ibus_adr);
               o_pass_cnt++;
            end
         end
         // Outputs must not move while a request waits for its ack
         if (ib_wait_q && (i_ibus_cyc !== 1'b1 || i_ibus_adr !== ib_adr_q)) begin
            $display("Fail t=%0t instruction request changed before its ack", $time);
            bp_errs++;
            o_fail_cnt++;
         end
         if (db_wait_q && (i_dbus_cyc !== 1'b1 || i_dbus_adr !== db_adr_q ||
                           i_dbus_dat !== db_dat_q || i_dbus_we !== db_we_q)) begin
            $display("Fail t=%0t data request changed before its ack", $time);
            bp_errs++;
            o_fail_cnt++;
         end
         if (ib_wait_q || db_wait_q) waits++;
         if (i_dbus_cyc && i_dbus_ack && i_dbus_we) compare_store();
      end
      ib_wait_q = i_rst_n && i_ibus_cyc && !i_ibus_ack;
      db_wait_q = i_rst_n && i_dbus_cyc && !i_dbus_ack;
      ib_adr_q  = i_ibus_adr;
      db_adr_q  = i_dbus_adr;
      db_dat_q  = i_dbus_dat;
      db_we_q   = i_dbus_we;
   end

endmodule

//--- verif/tb_bsc_top.sv
`timescale 1ns/1ps

module tb_bsc_top;

   localparam logic [31:0] RESET_PC = 32'h0;
   localparam int          TIMEOUT  = 20000;

   logic        clk;
   logic        rst_n;
   logic [31:0] ibus_adr;
   logic [31:0] ibus_rdt;
   logic        ibus_cyc;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic [31:0] dbus_rdt;
   logic        dbus_we;
   logic        dbus_cyc;
   logic        dbus_ack;
   logic        done;
   int          pass_cnt;
   int          fail_cnt;
   int          seed;
   int          ib_delay;
   int          db_delay;
   int          cycles;
   logic [31:0] mem [0:255];

   bsc_top #(.RESET_PC(RESET_PC)) i_dut (
      .clk(clk), .i_rst_n(rst_n),
      .o_ibus_adr(ibus_adr), .o_ibus_cyc(ibus_cyc), .i_ibus_rdt(ibus_rdt),
      .i_ibus_ack(ibus_ack), .o_dbus_adr(dbus_adr), .o_dbus_dat(dbus_dat),
      .o_dbus_we(dbus_we), .o_dbus_cyc(dbus_cyc), .i_dbus_rdt(dbus_rdt),
      .i_dbus_ack(dbus_ack));

   bsc_checker #(.RESET_PC(RESET_PC)) u_checker (
      .clk(clk), .i_rst_n(rst_n), .i_ibus_adr(ibus_adr), .i_ibus_cyc(ibus_cyc),
      .i_ibus_ack(ibus_ack), .i_dbus_adr(dbus_adr), .i_dbus_dat(dbus_dat),
      .i_dbus_we(dbus_we), .i_dbus_cyc(dbus_cyc), .i_dbus_ack(dbus_ack),
      .o_done(done), .o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt));

   always #5 clk = ~clk;

   // 0 to 5 wait cycles
   function automatic int draw_delay();
      return $unsigned($random(seed)) % 6;
   endfunction

   // Instruction ROM
   always @(negedge clk) begin
      if (!rst_n) begin
         ibus_ack = 1'b0;
         ib_delay = -1;
      end else if (ibus_ack) begin
         ibus_ack = 1'b0;
      end else if (ibus_cyc) begin
         if (ib_delay < 0) ib_delay = draw_delay();
         if (ib_delay == 0) begin
            ibus_rdt = mem[ibus_adr[9:2]];
            ibus_ack = 1'b1;
            ib_delay = -1;
         end else begin
            ib_delay--;
         end
      end
   end

   // Data RAM shares the same word array
   always @(negedge clk) begin
      if (!rst_n) begin
         dbus_ack = 1'b0;
         db_delay = -1;
      end else if (dbus_ack) begin
         dbus_ack = 1'b0;
      end else if (dbus_cyc) begin
         if (db_delay < 0) db_delay = draw_delay();
         if (db_delay == 0) begin
            if (dbus_we) mem[dbus_adr[9:2]] = dbus_dat;
            else dbus_rdt = mem[dbus_adr[9:2]];
            dbus_ack = 1'b1;
            db_delay = -1;
         end else begin
            db_delay--;
         end
      end
   end

   initial begin
      seed     = 32'h2a283aa6;
      clk      = 1'b0;
      rst_n    = 1'b0;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      dbus_rdt = '0;
      dbus_ack = 1'b0;
      ib_delay = -1;
      db_delay = -1;
      for (int i = 0; i < 256; i++) mem[i] = 32'hc0de0000 | i;
      $readmemh("verif/bsc_patterns.hex", mem);
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      cycles = 0;
      while (!done && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timeout: the final store did not arrive within %0d cycles", cycles);
      end
      $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (!done) begin
         $display("** FAIL **");
      end else if (fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- verif/bsc_patterns.hex
// One 32-bit hex word per line, loaded by word index
// @00 program, @40 initial data, @60 expected store address/data pairs
@00
00500093 // addi x1, x0, 5
00700113 // addi x2, x0, 7
402081B3 // sub  x3, x1, x2
12345237 // lui  x4, 0x12345
0F024293 // xori x5, x4, 0x0f0
0012E333 // or   x6, x5, x1
0061F3B3 // and  x7, x3, x6
20302023 // sw   x3, 0x200(x0)
20702223 // sw   x7, 0x204(x0)
00208033 // add  x0, x1, x2
20002423 // sw   x0, 0x208(x0)
10002403 // lw   x8, 0x100(x0)
12340413 // addi x8, x8, 0x123
20802623 // sw   x8, 0x20c(x0)
00208463 // beq  x1, x2, +8  not taken
20102823 // sw   x1, 0x210(x0)
00209463 // bne  x1, x2, +8  taken
3E202E23 // sw   x2, 0x3fc(x0)  wrong path
00108463 // beq  x1, x1, +8  taken
3E202E23 // sw   x2, 0x3fc(x0)  wrong path
00109463 // bne  x1, x1, +8  not taken
20202A23 // sw   x2, 0x214(x0)
008004EF // jal  x9, +8
3E202E23 // sw   x2, 0x3fc(x0)  wrong path
20902C23 // sw   x9, 0x218(x0)
0000006F // jal  x0, 0
@40
7FFFFFF0
@60
00000200 FFFFFFFE
00000204 123450F4
00000208 00000000
0000020C 80000113
00000210 00000005
00000214 00000007
00000218 0000005C
FFFFFFFF

//--- list.f
src/bsc_pkg.sv
src/bsc_decode.sv
src/bsc_state.sv
src/bsc_alu.sv
src/bsc_regfile.sv
src/bsc_ctrl.sv
src/bsc_mem_if.sv
src/bsc_top.sv
verif/bsc_checker.sv
verif/tb_bsc_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bsc_top
FLIST     ?= list.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
